/* include/mmu_consts.svh */
/*
  Shared constants of the data-side MMU: table depth, segment bounds,
  TLB exception codes and the APB register map of the TLB registers.
  Included by every block that needs one of these values.
*/
`ifndef MMU_CONSTS_SVH
`define MMU_CONSTS_SVH

// joint TLB geometry
`define TLB_ENTRIES   8
`define TLB_IDX_W     3

// unmapped segment bounds, kseg2 start closes kseg1
`define KSEG0_BASE    32'h8000_0000
`define KSEG1_BASE    32'hA000_0000
`define KSEG2_BASE    32'hC000_0000

`define CACHE_ATTR    3'd3          // C field value for cacheable

// exception codes reported on the access port
`define EX_NONE       3'd0
`define EX_RD_REFILL  3'd1
`define EX_WR_REFILL  3'd2
`define EX_RD_INVALID 3'd3
`define EX_WR_INVALID 3'd4
`define EX_MODIFIED   3'd5

// APB register offsets
`define REG_ENTRYHI   8'h00
`define REG_ENTRYLO0  8'h04
`define REG_ENTRYLO1  8'h08
`define REG_INDEX     8'h0C
`define REG_CMD       8'h10         // write 1 to store the entry at Index

`endif

/* source/mmu_pkg.sv */
/*
  Types of the TLB itself: page halves, table entries, the buffered
  entry and the CP0-like register words seen over APB.
  An APB data word is read through tlbRegWord as EntryHi or EntryLo.
*/
package mmu_pkg;

    // one half of an even/odd page pair
    typedef struct packed {
        logic [19:0] pfn;
        logic [2:0]  c;               // cache attribute
        logic        d;               // dirty, i.e. writable
        logic        v;
    } pageAttr;

    // joint TLB entry covering two 4 KiB pages
    typedef struct packed {
        logic [18:0] vpn2;
        logic [7:0]  asid;
        logic        g;
        pageAttr     page0;           // even page, vaddr[12] = 0
        pageAttr     page1;           // odd page
    } tlbEntry;

    // entry held by the translation buffer
    typedef struct packed {
        tlbEntry entry;
        logic    found;               // table search matched when loaded
    } bufEntry;

    // EntryHi register layout
    typedef struct packed {
        logic [18:0] vpn2;
        logic [4:0]  rsvd;
        logic [7:0]  asid;
    } entryHiWord;

    // EntryLo0/EntryLo1 register layout
    typedef struct packed {
        logic [5:0]  rsvd;
        logic [19:0] pfn;
        logic [2:0]  c;
        logic        d;
        logic        v;
        logic        g;
    } entryLoWord;

    // one APB word, decoded by offset
    typedef union packed {
        entryHiWord hi;
        entryLoWord lo;
    } tlbRegWord;

endpackage

/* source/mem_pkg.sv */
/*
  Types of the access port between the pipeline and the data MMU.
  The memory stage drives memReq and reads back xlatResult in the
  same cycle, holding the request while stall is high.
*/
package mem_pkg;

    // load/store request from the memory stage
    typedef struct packed {
        logic [31:0] vaddr;
        logic        load;
        logic        store;           // load wins if both are set
    } memReq;

    // translation outcome
    typedef struct packed {
        logic [31:0] paddr;
        logic        cached;
        logic        ok;              // access may proceed
        logic [2:0]  exc;             // one of the EX_* codes
    } xlatResult;

endpackage

/* source/tlbRegs.sv */
/*
  APB slave holding EntryHi, EntryLo0, EntryLo1 and Index.
  Writing 1 to the command register pulses tlbWe in the next cycle,
  storing the assembled entry at Index. Every write also pulses flush.
*/
`include "mmu_consts.svh"

module tlbRegs (
    input  logic                  clk,
    input  logic                  rstN,
    input  logic                  psel,
    input  logic                  penable,
    input  logic                  pwrite,
    input  logic [7:0]            paddr,
    input  logic [31:0]           pwdata,
    output logic [31:0]           prdata,
    output logic                  pready,
    output logic                  pslverr,
    output logic                  tlbWe,
    output logic [`TLB_IDX_W-1:0] wrIdx,
    output mmu_pkg::tlbEntry      wrEntry,
    output logic [7:0]            curAsid,
    output logic                  flush
);
    import mmu_pkg::*;

    entryHiWord            entryHi;
    entryLoWord            entryLo0;
    entryLoWord            entryLo1;
    logic [`TLB_IDX_W-1:0] index;
    tlbRegWord             wrWord;
    logic                  access;
    logic                  wrAccess;
    logic                  legalOffset;

    function automatic pageAttr toPage(input entryLoWord lo);
        pageAttr p;
        p.pfn = lo.pfn;
        p.c   = lo.c;
        p.d   = lo.d;
        p.v   = lo.v;
        return p;
    endfunction

    assign wrWord   = pwdata;
    assign access   = psel & penable;
    assign wrAccess = access & pwrite;

    always_comb begin
        case (paddr)
            `REG_ENTRYHI, `REG_ENTRYLO0, `REG_ENTRYLO1,
            `REG_INDEX, `REG_CMD: legalOffset = 1'b1;
            default:              legalOffset = 1'b0;
        endcase
    end

    assign pready  = 1'b1;                    // zero wait states
    assign pslverr = access & ~legalOffset;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            entryHi  <= '0;
            entryLo0 <= '0;
            entryLo1 <= '0;
            index    <= '0;
        end else if (wrAccess) begin
            case (paddr)
                `REG_ENTRYHI:  entryHi  <= wrWord.hi;
                `REG_ENTRYLO0: entryLo0 <= wrWord.lo;
                `REG_ENTRYLO1: entryLo1 <= wrWord.lo;
                `REG_INDEX:    index    <= pwdata[`TLB_IDX_W-1:0];
                default:       ;
            endcase
        end
    end

    // command and flush pulses, one cycle after the APB write
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            tlbWe <= 1'b0;
            flush <= 1'b0;
        end else begin
            tlbWe <= wrAccess && (paddr == `REG_CMD) && pwdata[0];
            flush <= wrAccess;
        end
    end

    always_comb begin
        prdata = '0;
        if (access && !pwrite) begin
            case (paddr)
                `REG_ENTRYHI:  prdata = entryHi;
                `REG_ENTRYLO0: prdata = entryLo0;
                `REG_ENTRYLO1: prdata = entryLo1;
                `REG_INDEX:    prdata[`TLB_IDX_W-1:0] = index;
                default:       prdata = '0;   // command reads as zero
            endcase
        end
    end

    always_comb begin
        wrEntry.vpn2  = entryHi.vpn2;
        wrEntry.asid  = entryHi.asid;
        wrEntry.g     = entryLo0.g & entryLo1.g;  // global only if both halves say so
        wrEntry.page0 = toPage(entryLo0);
        wrEntry.page1 = toPage(entryLo1);
    end

    assign wrIdx   = index;
    assign curAsid = entryHi.asid;

endmodule

/* source/jointTlb.sv */
/*
  Fully associative joint TLB. Search is combinational on vpn2 and ASID,
  with all entries compared in parallel; writes land at the clock edge.
  Duplicate mappings are not supported, their hit data would be merged.
*/
`include "mmu_consts.svh"

module jointTlb (
    input  logic                  clk,
    input  logic                  rstN,
    input  logic                  tlbWe,
    input  logic [`TLB_IDX_W-1:0] wrIdx,
    input  mmu_pkg::tlbEntry      wrEntry,
    input  logic [7:0]            curAsid,
    input  logic [18:0]           searchVpn2,
    output mmu_pkg::tlbEntry      hitEntry,
    output logic                  found
);
    import mmu_pkg::*;

    tlbEntry                 entryTable [`TLB_ENTRIES];
    logic [`TLB_ENTRIES-1:0] entryValid;      // set once an entry is written
    logic [`TLB_ENTRIES-1:0] matchVec;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            entryValid <= '0;
        end else if (tlbWe) begin
            entryValid[wrIdx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (tlbWe) begin
            entryTable[wrIdx] <= wrEntry;
        end
    end

    always_comb begin
        for (int i = 0; i < `TLB_ENTRIES; i++) begin
            matchVec[i] = entryValid[i]
                        && (entryTable[i].vpn2 == searchVpn2)
                        && (entryTable[i].g || (entryTable[i].asid == curAsid));
        end
    end

    assign found = |matchVec;

    // and-or mux, no priority between entries
    always_comb begin
        hitEntry = '0;
        for (int i = 0; i < `TLB_ENTRIES; i++) begin
            if (matchVec[i]) begin
                hitEntry = tlbEntry'(hitEntry | entryTable[i]);
            end
        end
    end

endmodule

/* source/dtlbBuffer.sv */
/*
  One-entry data translation buffer in front of the joint TLB.
  kseg0/kseg1 map directly; other addresses go through the buffered entry,
  which is refilled by a two-cycle idle/search miss sequence.
  Classifies refill, invalid and modified exceptions for loads and stores.
*/
`include "mmu_consts.svh"

module dtlbBuffer (
    input  logic                clk,
    input  logic                rstN,
    input  logic                flush,
    input  mem_pkg::memReq      req,
    input  mmu_pkg::tlbEntry    hitEntry,
    input  logic                found,
    output logic [18:0]         searchVpn2,
    output mem_pkg::xlatResult  res,
    output logic                stall
);
    import mmu_pkg::*;

    typedef enum logic {
        IDLE,
        SEARCH
    } fsmState;

    fsmState state;
    fsmState nextState;
    bufEntry buffer;
    pageAttr page;
    logic    access;
    logic    inKseg0;
    logic    inKseg1;
    logic    direct;
    logic    bufHit;
    logic    bufLoad;

    assign access  = req.load | req.store;
    assign inKseg0 = (req.vaddr >= `KSEG0_BASE) && (req.vaddr < `KSEG1_BASE);
    assign inKseg1 = (req.vaddr >= `KSEG1_BASE) && (req.vaddr < `KSEG2_BASE);
    assign direct  = inKseg0 | inKseg1;

    // no access or unmapped segment never misses
    assign bufHit = !access || direct || (req.vaddr[31:13] == buffer.entry.vpn2);
    assign stall  = ~bufHit;

    assign searchVpn2 = req.vaddr[31:13];

    always_comb begin
        nextState = IDLE;
        if (state == IDLE && !bufHit) begin
            nextState = SEARCH;
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state <= IDLE;
        end else begin
            state <= nextState;
        end
    end

    assign bufLoad = (state == SEARCH) && !bufHit;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            buffer <= '0;
        end else if (flush) begin
            buffer <= '0;                     // flush beats a pending load
        end else if (bufLoad) begin
            buffer.entry      <= hitEntry;
            buffer.entry.vpn2 <= req.vaddr[31:13]; // tag with the request, even on a miss
            buffer.found      <= found;
        end
    end

    assign page = req.vaddr[12] ? buffer.entry.page1 : buffer.entry.page0;

    always_comb begin
        if (inKseg1) begin
            res.paddr  = req.vaddr - `KSEG1_BASE;
            res.cached = 1'b0;
        end else if (inKseg0) begin
            res.paddr  = req.vaddr - `KSEG0_BASE;
            res.cached = 1'b1;
        end else begin
            res.paddr  = {page.pfn, req.vaddr[11:0]};
            res.cached = (page.c == `CACHE_ATTR);
        end
    end

    // exception priority: refill, invalid, modified
    always_comb begin
        res.exc = `EX_NONE;
        if (access && !direct && bufHit) begin
            if (!buffer.found) begin
                res.exc = req.load ? `EX_RD_REFILL : `EX_WR_REFILL;
            end else if (!page.v) begin
                res.exc = req.load ? `EX_RD_INVALID : `EX_WR_INVALID;
            end else if (req.store && !req.load && !page.d) begin
                res.exc = `EX_MODIFIED;
            end
        end
    end

    assign res.ok = access && bufHit && (res.exc == `EX_NONE);

endmodule

/* source/dataMmu.sv */
/*
  Data-side MMU top: TLB registers on APB, the joint TLB and the
  one-entry translation buffer serving the memory stage.
*/
`include "mmu_consts.svh"

module dataMmu (
    input  logic               clk,
    input  logic               rstN,
    input  logic               psel,
    input  logic               penable,
    input  logic               pwrite,
    input  logic [7:0]         paddr,
    input  logic [31:0]        pwdata,
    output logic [31:0]        prdata,
    output logic               pready,
    output logic               pslverr,
    input  mem_pkg::memReq     req,
    output mem_pkg::xlatResult res,
    output logic               stall
);
    import mmu_pkg::*;

    logic                  tlbWe;
    logic [`TLB_IDX_W-1:0] wrIdx;
    tlbEntry               wrEntry;
    logic [7:0]            curAsid;
    logic                  flush;
    logic [18:0]           searchVpn2;
    tlbEntry               hitEntry;
    logic                  found;

    tlbRegs i_regs (
        .clk, .rstN,
        .psel, .penable, .pwrite, .paddr, .pwdata,
        .prdata, .pready, .pslverr,
        .tlbWe, .wrIdx, .wrEntry, .curAsid, .flush
    );

    jointTlb i_jtlb (
        .clk, .rstN,
        .tlbWe, .wrIdx, .wrEntry,
        .curAsid, .searchVpn2,
        .hitEntry, .found
    );

    dtlbBuffer i_dbuf (
        .clk, .rstN, .flush,
        .req, .hitEntry, .found,
        .searchVpn2, .res, .stall
    );

endmodule

/* bench/dataMmu_checker.sv */
/*
  Assertion module bound to the data MMU top level. It keeps its own copy of
  the TLB registers and table, built from APB writes seen at the ports, and
  checks stall and every translation result against that model.
*/
`include "mmu_consts.svh"

module dataMmu_checker (
    input logic               clk,
    input logic               rstN,
    input logic               psel,
    input logic               penable,
    input logic               pwrite,
    input logic [7:0]         paddr,
    input logic [31:0]        pwdata,
    input mem_pkg::memReq     req,
    input mem_pkg::xlatResult res,
    input logic               stall
);
    timeunit 1ns;
    timeprecision 100ps;
    import mmu_pkg::*;
    import mem_pkg::*;

    tlbEntry                 modelTable [`TLB_ENTRIES];
    logic [`TLB_ENTRIES-1:0] modelValid;
    entryHiWord              hiReg;
    entryLoWord              lo0Reg;
    entryLoWord              lo1Reg;
    logic [`TLB_IDX_W-1:0]   idxReg;
    logic                    weDue;             // table write one cycle after CMD
    tlbRegWord               apbWord;
    xlatResult               expRes;
    logic                    access;
    logic                    inK0;
    logic                    inK1;
    logic                    mapped;
    int                      failCount = 0;

    assign apbWord = pwdata;
    assign access  = req.load | req.store;
    assign inK0    = req.vaddr[31:29] == 3'b100;
    assign inK1    = req.vaddr[31:29] == 3'b101;
    assign mapped  = access && !inK0 && !inK1;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            hiReg      <= '0;
            lo0Reg     <= '0;
            lo1Reg     <= '0;
            idxReg     <= '0;
            weDue      <= 1'b0;
            modelValid <= '0;
        end else begin
            if (weDue) begin
                modelValid[idxReg]      <= 1'b1;
                modelTable[idxReg].vpn2 <= hiReg.vpn2;
                modelTable[idxReg].asid <= hiReg.asid;
                modelTable[idxReg].g    <= lo0Reg.g && lo1Reg.g;
                modelTable[idxReg].page0 <= {lo0Reg.pfn, lo0Reg.c, lo0Reg.d, lo0Reg.v};
                modelTable[idxReg].page1 <= {lo1Reg.pfn, lo1Reg.c, lo1Reg.d, lo1Reg.v};
            end
            weDue <= psel && penable && pwrite && paddr == `REG_CMD && pwdata[0];
            if (psel && penable && pwrite) begin
                case (paddr)
                    `REG_ENTRYHI:  hiReg  <= apbWord.hi;
                    `REG_ENTRYLO0: lo0Reg <= apbWord.lo;
                    `REG_ENTRYLO1: lo1Reg <= apbWord.lo;
                    `REG_INDEX:    idxReg <= pwdata[`TLB_IDX_W-1:0];
                    default:       ;
                endcase
            end
        end
    end

    // expected translation of a mapped access
    always_comb begin
        tlbEntry hit;
        logic    hitFound;
        pageAttr pg;
        hit      = '0;
        hitFound = 1'b0;
        for (int i = 0; i < `TLB_ENTRIES; i++) begin
            if (modelValid[i] && modelTable[i].vpn2 == req.vaddr[31:13]
                    && (modelTable[i].g || modelTable[i].asid == hiReg.asid)) begin
                hit      = modelTable[i];
                hitFound = 1'b1;
            end
        end
        pg            = req.vaddr[12] ? hit.page1 : hit.page0;
        expRes.paddr  = {pg.pfn, req.vaddr[11:0]};
        expRes.cached = pg.c == `CACHE_ATTR;
        if (!hitFound) begin
            expRes.exc = req.load ? `EX_RD_REFILL : `EX_WR_REFILL;
        end else if (!pg.v) begin
            expRes.exc = req.load ? `EX_RD_INVALID : `EX_WR_INVALID;
        end else if (!req.load && !pg.d) begin
            expRes.exc = `EX_MODIFIED;
        end else begin
            expRes.exc = `EX_NONE;
        end
        expRes.ok = expRes.exc == `EX_NONE;
    end

    resetQuiet: assert property (@(posedge clk)
        !rstN |-> !stall && !res.ok && res.exc == `EX_NONE)
        else begin $error("outputs active in reset"); failCount++; end

    idleQuiet: assert property (@(posedge clk) disable iff (!rstN)
        !access |-> !stall && !res.ok && res.exc == `EX_NONE)
        else begin $error("outputs active without access"); failCount++; end

    kseg0Map: assert property (@(posedge clk) disable iff (!rstN)
        access && inK0 |-> !stall && res.ok && res.cached && res.exc == `EX_NONE
            && res.paddr == {3'b000, req.vaddr[28:0]})
        else begin $error("kseg0 translation wrong"); failCount++; end

    kseg1Map: assert property (@(posedge clk) disable iff (!rstN)
        access && inK1 |-> !stall && res.ok && !res.cached && res.exc == `EX_NONE
            && res.paddr == {3'b000, req.vaddr[28:0]})
        else begin $error("kseg1 translation wrong"); failCount++; end

    stallOnlyMapped: assert property (@(posedge clk) disable iff (!rstN)
        stall |-> mapped)
        else begin $error("stall outside a mapped access"); failCount++; end

    mappedExc: assert property (@(posedge clk) disable iff (!rstN)
        mapped && !stall |-> res.exc == expRes.exc && res.ok == expRes.ok)
        else begin $error("mapped exception or ok wrong"); failCount++; end

    mappedAddr: assert property (@(posedge clk) disable iff (!rstN)
        mapped && !stall && expRes.ok |-> res.paddr == expRes.paddr
            && res.cached == expRes.cached)
        else begin $error("mapped paddr or cached wrong"); failCount++; end

    stallSecond: assert property (@(posedge clk) disable iff (!rstN)
        $past(stall) && !$past(stall, 2) |-> stall)
        else begin $error("stall shorter than two cycles"); failCount++; end

    stallEnds: assert property (@(posedge clk) disable iff (!rstN)
        $past(stall) && $past(stall, 2) |-> !stall)
        else begin $error("stall longer than two cycles"); failCount++; end

endmodule

bind dataMmu dataMmu_checker i_checker (.*);

/* bench/dataMmu_tb.sv */
/*
  Testbench of the data MMU. Loads TLB entries over APB, runs loads and
  stores through the access port and leaves result checking to the bound
  checker; APB read data is compared here. One line per test, then counts.
*/
`include "mmu_consts.svh"

module dataMmu_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import mem_pkg::*;

    logic        clk;
    logic        rstN;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [7:0]  paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
    memReq       req;
    xlatResult   res;
    logic        stall;
    int          seed = 27;
    int          benchErrors = 0;
    int          testsFailed = 0;
    int          testsRun = 0;
    int          benchMark;
    int          assertMark;

    dataMmu i_dut (.*);

    always #50 clk = ~clk;

    initial begin
        #(6 * 300 * 100);
        $display("watchdog expired before the tests completed");
        $display("Test failures found");
        $finish;
    end

    function automatic logic [31:0] loWord(input logic [19:0] pfn, input logic [2:0] c,
                                           input logic d, input logic v, input logic g);
        return {6'b0, pfn, c, d, v, g};
    endfunction

    task automatic apbWrite(input logic [7:0] addr, input logic [31:0] data);
        @(negedge clk);
        psel   = 1'b1;
        pwrite = 1'b1;
        paddr  = addr;
        pwdata = data;
        @(negedge clk);
        penable = 1'b1;
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apbReadCheck(input logic [7:0] addr, input logic [31:0] expData,
                                input logic expErr);
        logic [31:0] got;
        logic        err;
        logic        rdy;
        @(negedge clk);
        psel   = 1'b1;
        pwrite = 1'b0;
        paddr  = addr;
        @(negedge clk);
        penable = 1'b1;
        @(posedge clk);
        got = prdata;
        err = pslverr;
        rdy = pready;
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
        if (got !== expData) begin
            $display("[ERROR] prdata at offset %h: got %h, expected %h", addr, got, expData);
            benchErrors++;
        end
        if (err !== expErr) begin
            $display("[ERROR] pslverr at offset %h: got %h, expected %h", addr, err, expErr);
            benchErrors++;
        end
        if (rdy !== 1'b1) begin
            $display("[ERROR] pready at offset %h: got %h, expected %h", addr, rdy, 1'b1);
            benchErrors++;
        end
    endtask

    // full entry load: EntryHi, both EntryLo, Index, then the command
    task automatic writeEntry(input int idx, input logic [18:0] vpn2, input logic [7:0] asid,
                              input logic [31:0] lo0, input logic [31:0] lo1);
        apbWrite(`REG_ENTRYHI, {vpn2, 5'b0, asid});
        apbWrite(`REG_ENTRYLO0, lo0);
        apbWrite(`REG_ENTRYLO1, lo1);
        apbWrite(`REG_INDEX, idx);
        apbWrite(`REG_CMD, 32'h1);
        repeat (2) @(negedge clk);
    endtask

    // hold the request until a cycle without stall
    task automatic access(input logic [31:0] vaddr, input logic load, input logic store);
        logic stalled;
        int   waited;
        waited    = 0;
        req.vaddr = vaddr;
        req.load  = load;
        req.store = store;
        do begin
            #10 stalled = stall;
            @(negedge clk);
            waited++;
        end while (stalled && waited < 8);
        if (stalled) begin
            $display("access to %h never left stall", vaddr);
            benchErrors++;
        end
        req = '0;
    endtask

    task automatic startTest;
        benchMark  = benchErrors;
        assertMark = i_dut.i_checker.failCount;
    endtask

    task automatic endTest(input string name);
        int errs;
        errs = benchErrors - benchMark + i_dut.i_checker.failCount - assertMark;
        testsRun++;
        if (errs != 0) begin
            testsFailed++;
            $display("test %0d %s: FAIL with %0d errors", testsRun, name, errs);
        end else begin
            $display("test %0d %s: PASS", testsRun, name);
        end
    endtask

    initial begin
        logic [31:0] hi;
        logic [31:0] lo0;
        logic [31:0] lo1;
        logic [31:0] idx;
        clk     = 1'b0;
        rstN    = 1'b0;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        req     = '0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        rstN = 1'b1;

        startTest();
        access(32'h8001_2345, 1'b1, 1'b0);
        access(32'h9FFF_FFFC, 1'b0, 1'b1);
        access(32'hA000_1000, 1'b1, 1'b0);
        access(32'hBFFF_FFF0, 1'b0, 1'b1);
        endTest("direct segments");

        startTest();
        writeEntry(0, 19'h00400, 8'h05, loWord(20'h12345, 3'd3, 1'b1, 1'b1, 1'b1),
                   loWord(20'h54321, 3'd2, 1'b1, 1'b1, 1'b1));
        access(32'h0080_0123, 1'b1, 1'b0);    // miss, then even page
        access(32'h0080_1456, 1'b1, 1'b0);    // odd page hits
        access(32'h0080_0FFC, 1'b0, 1'b1);
        endTest("mapped miss and hit");

        startTest();
        access(32'h0100_0000, 1'b1, 1'b0);
        access(32'h0200_0004, 1'b0, 1'b1);
        endTest("refill");

        startTest();
        writeEntry(1, 19'h01800, 8'h05, loWord(20'h0AAAA, 3'd3, 1'b1, 1'b0, 1'b1),
                   loWord(20'h0BBBB, 3'd2, 1'b0, 1'b1, 1'b1));
        access(32'h0300_0010, 1'b1, 1'b0);
        access(32'h0300_0010, 1'b0, 1'b1);
        access(32'h0300_1010, 1'b0, 1'b1);    // d=0 store
        access(32'h0300_1010, 1'b1, 1'b0);
        endTest("invalid and modified");

        startTest();
        hi  = $random(seed);
        lo0 = $random(seed);
        lo1 = $random(seed);
        idx = $random(seed);
        apbWrite(`REG_ENTRYHI, hi);
        apbWrite(`REG_ENTRYLO0, lo0);
        apbWrite(`REG_ENTRYLO1, lo1);
        apbWrite(`REG_INDEX, idx);
        apbReadCheck(`REG_ENTRYHI, hi, 1'b0);
        apbReadCheck(`REG_ENTRYLO0, lo0, 1'b0);
        apbReadCheck(`REG_ENTRYLO1, lo1, 1'b0);
        apbReadCheck(`REG_INDEX, idx & 32'h7, 1'b0);
        apbReadCheck(`REG_CMD, 32'h0, 1'b0);
        apbReadCheck(8'h14, 32'h0, 1'b1);
        access(32'h0080_0040, 1'b1, 1'b0);    // buffer holds the old pfn
        writeEntry(0, 19'h00400, 8'h05, loWord(20'h0ABCD, 3'd3, 1'b1, 1'b1, 1'b1),
                   loWord(20'h0DCBA, 3'd3, 1'b1, 1'b1, 1'b1));
        access(32'h0080_0040, 1'b1, 1'b0);    // new pfn after flush
        writeEntry(2, 19'h02000, 8'h09, loWord(20'h01111, 3'd3, 1'b1, 1'b1, 1'b0),
                   loWord(20'h02222, 3'd3, 1'b1, 1'b1, 1'b0));
        access(32'h0400_0000, 1'b1, 1'b0);
        apbWrite(`REG_ENTRYHI, {19'h0, 5'b0, 8'h03});
        repeat (2) @(negedge clk);
        access(32'h0400_0000, 1'b1, 1'b0);    // other ASID refills
        endTest("registers and flush");

        startTest();
        for (int i = 0; i < 8; i++) begin
            req.vaddr = $random(seed);
            req.load  = 1'b0;
            req.store = 1'b0;
            @(negedge clk);
        end
        req = '0;
        @(negedge clk);
        endTest("no access");

        $display("tests run %0d, failed %0d, bench errors %0d, assertion failures %0d",
                 testsRun, testsFailed, benchErrors, i_dut.i_checker.failCount);
        if (testsFailed == 0 && benchErrors == 0 && i_dut.i_checker.failCount == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

/* sim.f */
+incdir+include
source/mmu_pkg.sv
source/mem_pkg.sv
source/tlbRegs.sv
source/jointTlb.sv
source/dtlbBuffer.sv
source/dataMmu.sv
bench/dataMmu_checker.sv
bench/dataMmu_tb.sv

/* run.sh */
#!/bin/sh
# Build the data MMU testbench with Verilator and run it.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f sim.f \
    --top-module dataMmu_tb -o simv
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

out=$(./obj_dir/simv +verilator+error+limit+1000)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx "All tests passed!"; then
    exit 0
fi
exit 1
